// ==== src/mcsr_config.svh ====
// widths, CSR addresses, reset values and fixed ID values for the machine CSR block
`ifndef MCSR_CONFIG_SVH
`define MCSR_CONFIG_SVH

`define MCSR_DATA_WIDTH        32
`define MCSR_ADDR_WIDTH        32
`define MCSR_INSTR_WIDTH       32
`define MCSR_CSR_ADDR_WIDTH    12
`define MCSR_MISA_EXT_WIDTH    26

// implemented machine registers
`define MCSR_MVENDORID_ADDR    12'hF11
`define MCSR_MARCHID_ADDR      12'hF12
`define MCSR_MIMPID_ADDR       12'hF13
`define MCSR_MHARTID_ADDR      12'hF14
`define MCSR_MSTATUS_ADDR      12'h300
`define MCSR_MISA_ADDR         12'h301
`define MCSR_MIE_ADDR          12'h304
`define MCSR_MTVEC_ADDR        12'h305
`define MCSR_MEPC_ADDR         12'h341
`define MCSR_MCAUSE_ADDR       12'h342
`define MCSR_MTVAL_ADDR        12'h343
`define MCSR_MIP_ADDR          12'h344
`define MCSR_TCM_CTRL_ADDR     12'h7C0    // custom machine rw space
`define MCSR_DTCM_START_ADDR_ADDR 12'h7C1

// dummy registers, read as zero
`define MCSR_STVEC_ADDR        12'h105
`define MCSR_SATP_ADDR         12'h180
`define MCSR_PMPCFG0_ADDR      12'h3A0
`define MCSR_PMPADDR0_ADDR     12'h3B0
`define MCSR_MEDELEG_ADDR      12'h302
`define MCSR_MIDELEG_ADDR      12'h303

`define MCSR_VECTOR_ENTRY      32'h0000_0080
`define MCSR_DTCM_START_ADDR   32'h0001_8000
`define MCSR_MISA_RESET        26'h000_0100    // I base only
`define MCSR_MISA_MXL          2'h1            // 32-bit machine
`define MCSR_MIMPID_VALUE      32'h1000_0000

`define MCSR_MSTATUS_MIE_BIT   3
`define MCSR_MSTATUS_MPIE_BIT  7
`define MCSR_MIE_MEIE_BIT      11
`define MCSR_MIE_MTIE_BIT      7
`define MCSR_MIP_MEIP_BIT      11
`define MCSR_MIP_MTIP_BIT      7

`endif

// ==== src/mcsr_pkg.sv ====
// shared CSR enums, access and trap structs, and the write/set/clear helper
`include "mcsr_config.svh"

package mcsr_pkg;

	typedef enum logic [1:0]
	{
		CSR_OP_WRITE = 2'd0,
		CSR_OP_SET   = 2'd1,
		CSR_OP_CLEAR = 2'd2
	} csr_op_e;

	typedef enum logic [4:0]
	{
		CSR_REG_MVENDORID,
		CSR_REG_MARCHID,
		CSR_REG_MIMPID,
		CSR_REG_MHARTID,
		CSR_REG_MSTATUS,
		CSR_REG_MISA,
		CSR_REG_MIE,
		CSR_REG_MTVEC,
		CSR_REG_MEPC,
		CSR_REG_MCAUSE,
		CSR_REG_MTVAL,
		CSR_REG_MIP,
		CSR_REG_TCM_CTRL,
		CSR_REG_DTCM_START,
		CSR_REG_DUMMY,    // legal, reads zero
		CSR_REG_NONE      // no such register
	} csr_reg_e;

	// one access from the decoder
	typedef struct packed
	{
		logic [`MCSR_CSR_ADDR_WIDTH-1:0] addr;
		csr_op_e                         op;
		logic                            rd;
		logic                            wr;
		logic                            valid_rd;
		logic                            valid_wr;
		logic [`MCSR_DATA_WIDTH-1:0]     wdata;
		logic [`MCSR_INSTR_WIDTH-1:0]    instr;
	} csr_req_t;

	// decoded write, en already qualified by legality
	typedef struct packed
	{
		csr_reg_e                    sel;
		csr_op_e                     op;
		logic [`MCSR_DATA_WIDTH-1:0] wdata;
		logic                        en;
	} csr_wr_t;

	typedef struct packed
	{
		logic                        meip;
		logic                        mtip;
		logic                        valid_interrupt;
		logic                        mret;
		logic [`MCSR_ADDR_WIDTH-1:0] mepc;
		logic [`MCSR_DATA_WIDTH-1:0] mcause;
		logic [`MCSR_DATA_WIDTH-1:0] mtval;
	} trap_info_t;

	typedef struct packed
	{
		logic                        meie;
		logic                        mtie;
		logic                        mstatus_mie;
		logic [1:0]                  mtvec_mode;
		logic [`MCSR_ADDR_WIDTH-1:0] mtvec_base;    // low two bits zero
	} trap_ctrl_t;

	// new register value for write, set or clear
	function automatic logic [`MCSR_DATA_WIDTH-1:0] csr_apply(
		input csr_op_e                     op,
		input logic [`MCSR_DATA_WIDTH-1:0] old_val,
		input logic [`MCSR_DATA_WIDTH-1:0] data
	);
		case (op)
			CSR_OP_WRITE: return data;
			CSR_OP_SET:   return old_val | data;
			CSR_OP_CLEAR: return old_val & ~data;
			default:      return old_val;    // unused encoding, hold
		endcase
	endfunction

endpackage

// ==== src/csr_addr_decode.sv ====
// CSR address decode, write qualification and illegal access detection
`timescale 1ns/1ns
`include "mcsr_config.svh"

module csr_addr_decode (
	input  mcsr_pkg::csr_req_t            req,
	output mcsr_pkg::csr_reg_e            sel,
	output mcsr_pkg::csr_wr_t             wr,
	output logic                          mepc_sel,
	output logic                          mcause_sel,
	output logic                          mtval_sel,
	output logic                          csr_illegal_access,
	output logic [`MCSR_INSTR_WIDTH-1:0]  illegal_instr
);

	logic is_id;      // read-only ID register
	logic no_reg;     // address not implemented
	logic wr_ro;

	always_comb
	begin
		case (req.addr)
			`MCSR_MVENDORID_ADDR:       sel = mcsr_pkg::CSR_REG_MVENDORID;
			`MCSR_MARCHID_ADDR:         sel = mcsr_pkg::CSR_REG_MARCHID;
			`MCSR_MIMPID_ADDR:          sel = mcsr_pkg::CSR_REG_MIMPID;
			`MCSR_MHARTID_ADDR:         sel = mcsr_pkg::CSR_REG_MHARTID;
			`MCSR_MSTATUS_ADDR:         sel = mcsr_pkg::CSR_REG_MSTATUS;
			`MCSR_MISA_ADDR:            sel = mcsr_pkg::CSR_REG_MISA;
			`MCSR_MIE_ADDR:             sel = mcsr_pkg::CSR_REG_MIE;
			`MCSR_MTVEC_ADDR:           sel = mcsr_pkg::CSR_REG_MTVEC;
			`MCSR_MEPC_ADDR:            sel = mcsr_pkg::CSR_REG_MEPC;
			`MCSR_MCAUSE_ADDR:          sel = mcsr_pkg::CSR_REG_MCAUSE;
			`MCSR_MTVAL_ADDR:           sel = mcsr_pkg::CSR_REG_MTVAL;
			`MCSR_MIP_ADDR:             sel = mcsr_pkg::CSR_REG_MIP;
			`MCSR_TCM_CTRL_ADDR:        sel = mcsr_pkg::CSR_REG_TCM_CTRL;
			`MCSR_DTCM_START_ADDR_ADDR: sel = mcsr_pkg::CSR_REG_DTCM_START;
			`MCSR_STVEC_ADDR,
			`MCSR_SATP_ADDR,
			`MCSR_PMPCFG0_ADDR,
			`MCSR_PMPADDR0_ADDR,
			`MCSR_MEDELEG_ADDR,
			`MCSR_MIDELEG_ADDR:         sel = mcsr_pkg::CSR_REG_DUMMY;
			default:                    sel = mcsr_pkg::CSR_REG_NONE;
		endcase
	end

	assign is_id = (sel == mcsr_pkg::CSR_REG_MVENDORID) || (sel == mcsr_pkg::CSR_REG_MARCHID) ||
		(sel == mcsr_pkg::CSR_REG_MIMPID) || (sel == mcsr_pkg::CSR_REG_MHARTID);
	assign no_reg = (sel == mcsr_pkg::CSR_REG_NONE);
	assign wr_ro  = is_id && req.wr;

	assign csr_illegal_access = ((req.rd || req.wr) && no_reg) || wr_ro;
	assign illegal_instr = csr_illegal_access ? req.instr : '0;

	// trap controller owns these three
	assign mepc_sel   = (sel == mcsr_pkg::CSR_REG_MEPC);
	assign mcause_sel = (sel == mcsr_pkg::CSR_REG_MCAUSE);
	assign mtval_sel  = (sel == mcsr_pkg::CSR_REG_MTVAL);

	assign wr.sel   = sel;
	assign wr.op    = req.op;
	assign wr.wdata = req.wdata;
	assign wr.en    = req.valid_wr && !no_reg && !is_id;

endmodule

// ==== src/csr_trap_regs.sv ====
// mstatus, mie and mtvec registers with interrupt entry and mret handling
`timescale 1ns/1ns
`include "mcsr_config.svh"

module csr_trap_regs (
	input  logic                 cpu_clk,
	input  logic                 cpu_rstn,
	input  mcsr_pkg::csr_wr_t    wr,
	input  mcsr_pkg::trap_info_t trap,
	output mcsr_pkg::trap_ctrl_t trap_ctrl,
	output logic                 mstatus_mpie
);

	logic                        mstatus_mie;
	logic                        int_active;    // inside an interrupt handler
	logic                        meie;
	logic                        mtie;
	logic [`MCSR_DATA_WIDTH-1:0] mtvec;
	logic [`MCSR_DATA_WIDTH-1:0] mstatus_cur;
	logic [`MCSR_DATA_WIDTH-1:0] mstatus_new;
	logic [`MCSR_DATA_WIDTH-1:0] mie_cur;
	logic [`MCSR_DATA_WIDTH-1:0] mie_new;
	logic [`MCSR_DATA_WIDTH-1:0] mtvec_new;
	logic                        mret_taken;

	// current values in register layout
	always_comb
	begin
		mstatus_cur = '0;
		mstatus_cur[`MCSR_MSTATUS_MIE_BIT]  = mstatus_mie;
		mstatus_cur[`MCSR_MSTATUS_MPIE_BIT] = mstatus_mpie;
		mie_cur = '0;
		mie_cur[`MCSR_MIE_MEIE_BIT] = meie;
		mie_cur[`MCSR_MIE_MTIE_BIT] = mtie;
	end

	assign mstatus_new = mcsr_pkg::csr_apply(wr.op, mstatus_cur, wr.wdata);
	assign mie_new     = mcsr_pkg::csr_apply(wr.op, mie_cur, wr.wdata);
	assign mtvec_new   = mcsr_pkg::csr_apply(wr.op, mtvec, wr.wdata);
	assign mret_taken  = trap.mret && int_active;    // plain mret leaves mstatus alone

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
			int_active <= 1'b0;
		else if (trap.mret)
			int_active <= 1'b0;
		else if (trap.valid_interrupt)
			int_active <= 1'b1;
	end

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end
		else if (mret_taken)
		begin
			mstatus_mie  <= mstatus_mpie;
			mstatus_mpie <= 1'b1;
		end
		else if (trap.valid_interrupt)
		begin
			mstatus_mie  <= 1'b0;    // handler runs with interrupts off
			mstatus_mpie <= mstatus_mie;
		end
		else if (wr.en && (wr.sel == mcsr_pkg::CSR_REG_MSTATUS))
		begin
			mstatus_mie  <= mstatus_new[`MCSR_MSTATUS_MIE_BIT];
			mstatus_mpie <= mstatus_new[`MCSR_MSTATUS_MPIE_BIT];
		end
	end

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			meie  <= 1'b1;
			mtie  <= 1'b1;
			mtvec <= `MCSR_VECTOR_ENTRY;
		end
		else
		begin
			if (wr.en && (wr.sel == mcsr_pkg::CSR_REG_MIE))
			begin
				meie <= mie_new[`MCSR_MIE_MEIE_BIT];
				mtie <= mie_new[`MCSR_MIE_MTIE_BIT];
			end
			if (wr.en && (wr.sel == mcsr_pkg::CSR_REG_MTVEC))
				mtvec <= mtvec_new;    // whole word, mode in 1:0
		end
	end

	always_comb
	begin
		trap_ctrl.meie        = meie;
		trap_ctrl.mtie        = mtie;
		trap_ctrl.mstatus_mie = mstatus_mie;
		trap_ctrl.mtvec_mode  = mtvec[1:0];
		trap_ctrl.mtvec_base  = {mtvec[`MCSR_DATA_WIDTH-1:2], 2'b00};
	end

endmodule

// ==== src/csr_isa_tcm_regs.sv ====
// misa, TCM control and DTCM start address registers
`timescale 1ns/1ns
`include "mcsr_config.svh"

module csr_isa_tcm_regs (
	input  logic                            cpu_clk,
	input  logic                            cpu_rstn,
	input  mcsr_pkg::csr_wr_t               wr,
	output logic [`MCSR_MISA_EXT_WIDTH-1:0] misa,
	output logic                            dtcm_en,
	output logic [`MCSR_ADDR_WIDTH-1:0]     dtcm_start_addr
);

	logic [`MCSR_DATA_WIDTH-1:0] misa_new;
	logic [`MCSR_DATA_WIDTH-1:0] tcm_new;
	logic [`MCSR_DATA_WIDTH-1:0] dtcm_start_new;
	logic                        misa_we;
	logic                        tcm_we;
	logic                        dtcm_start_we;

	// only the extension field is stored, MXL is fixed
	assign misa_new = mcsr_pkg::csr_apply(wr.op,
		{{(`MCSR_DATA_WIDTH-`MCSR_MISA_EXT_WIDTH){1'b0}}, misa}, wr.wdata);
	assign tcm_new = mcsr_pkg::csr_apply(wr.op,
		{{(`MCSR_DATA_WIDTH-1){1'b0}}, dtcm_en}, wr.wdata);
	assign dtcm_start_new = mcsr_pkg::csr_apply(wr.op, dtcm_start_addr, wr.wdata);

	assign misa_we       = wr.en && (wr.sel == mcsr_pkg::CSR_REG_MISA);
	assign tcm_we        = wr.en && (wr.sel == mcsr_pkg::CSR_REG_TCM_CTRL);
	assign dtcm_start_we = wr.en && (wr.sel == mcsr_pkg::CSR_REG_DTCM_START);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			misa            <= `MCSR_MISA_RESET;
			dtcm_en         <= 1'b1;    // dtcm on out of reset
			dtcm_start_addr <= `MCSR_DTCM_START_ADDR;
		end
		else
		begin
			if (misa_we)
				misa <= misa_new[`MCSR_MISA_EXT_WIDTH-1:0];
			if (tcm_we)
				dtcm_en <= tcm_new[0];
			if (dtcm_start_we)
				dtcm_start_addr <= dtcm_start_new;
		end
	end

endmodule

// ==== src/csr_read_mux.sv ====
// read data assembly for the selected CSR
`timescale 1ns/1ns
`include "mcsr_config.svh"

module csr_read_mux (
	input  mcsr_pkg::csr_reg_e              sel,
	input  logic                            valid_rd,
	input  logic [`MCSR_MISA_EXT_WIDTH-1:0] misa,
	input  logic                            mstatus_mpie,
	input  mcsr_pkg::trap_ctrl_t            trap_ctrl,
	input  logic                            dtcm_en,
	input  logic [`MCSR_ADDR_WIDTH-1:0]     dtcm_start_addr,
	input  mcsr_pkg::trap_info_t            trap,
	output logic [`MCSR_DATA_WIDTH-1:0]     read_data
);

	logic [`MCSR_DATA_WIDTH-1:0] rdata;

	always_comb
	begin
		rdata = '0;    // ID zeros, dummies and unknown
		case (sel)
			mcsr_pkg::CSR_REG_MIMPID:
				rdata = `MCSR_MIMPID_VALUE;
			mcsr_pkg::CSR_REG_MISA:
				rdata = {`MCSR_MISA_MXL, 4'h0, misa};
			mcsr_pkg::CSR_REG_MSTATUS:
			begin
				rdata[`MCSR_MSTATUS_MIE_BIT]  = trap_ctrl.mstatus_mie;
				rdata[`MCSR_MSTATUS_MPIE_BIT] = mstatus_mpie;
			end
			mcsr_pkg::CSR_REG_MIE:
			begin
				rdata[`MCSR_MIE_MEIE_BIT] = trap_ctrl.meie;
				rdata[`MCSR_MIE_MTIE_BIT] = trap_ctrl.mtie;
			end
			mcsr_pkg::CSR_REG_MIP:
			begin
				rdata[`MCSR_MIP_MEIP_BIT] = trap.meip;    // live pending lines
				rdata[`MCSR_MIP_MTIP_BIT] = trap.mtip;
			end
			mcsr_pkg::CSR_REG_MTVEC:
				rdata = {trap_ctrl.mtvec_base[`MCSR_DATA_WIDTH-1:2], trap_ctrl.mtvec_mode};
			mcsr_pkg::CSR_REG_MEPC:       rdata = trap.mepc;
			mcsr_pkg::CSR_REG_MCAUSE:     rdata = trap.mcause;
			mcsr_pkg::CSR_REG_MTVAL:      rdata = trap.mtval;
			mcsr_pkg::CSR_REG_TCM_CTRL:   rdata[0] = dtcm_en;
			mcsr_pkg::CSR_REG_DTCM_START: rdata = dtcm_start_addr;
			default:                      rdata = '0;
		endcase
	end

	assign read_data = valid_rd ? rdata : '0;

endmodule

// ==== src/mcsr_top.sv ====
// machine CSR block top, connecting decode, register banks and read mux
`timescale 1ns/1ns
`include "mcsr_config.svh"

module mcsr_top (
	input  logic                         cpu_clk,
	input  logic                         cpu_rstn,
	input  mcsr_pkg::csr_req_t           req,              // one access per cycle
	input  mcsr_pkg::trap_info_t         trap,
	output logic [`MCSR_DATA_WIDTH-1:0]  read_data,
	output logic                         mepc_sel,
	output logic                         mcause_sel,
	output logic                         mtval_sel,
	output logic                         csr_illegal_access,
	output logic [`MCSR_INSTR_WIDTH-1:0] illegal_instr,
	output mcsr_pkg::trap_ctrl_t         trap_ctrl,
	output logic                         dtcm_en,
	output logic [`MCSR_ADDR_WIDTH-1:0]  dtcm_start_addr
);

	mcsr_pkg::csr_reg_e              sel;
	mcsr_pkg::csr_wr_t               wr;
	logic                            mstatus_mpie;
	logic [`MCSR_MISA_EXT_WIDTH-1:0] misa;

	csr_addr_decode u_decode (
		.req                (req),
		.sel                (sel),
		.wr                 (wr),
		.mepc_sel           (mepc_sel),
		.mcause_sel         (mcause_sel),
		.mtval_sel          (mtval_sel),
		.csr_illegal_access (csr_illegal_access),
		.illegal_instr      (illegal_instr)
	);

	csr_trap_regs u_trap_regs (
		.cpu_clk      (cpu_clk),
		.cpu_rstn     (cpu_rstn),
		.wr           (wr),
		.trap         (trap),
		.trap_ctrl    (trap_ctrl),
		.mstatus_mpie (mstatus_mpie)
	);

	csr_isa_tcm_regs u_isa_tcm_regs (
		.cpu_clk         (cpu_clk),
		.cpu_rstn        (cpu_rstn),
		.wr              (wr),
		.misa            (misa),
		.dtcm_en         (dtcm_en),
		.dtcm_start_addr (dtcm_start_addr)
	);

	csr_read_mux u_read_mux (
		.sel             (sel),
		.valid_rd        (req.valid_rd),
		.misa            (misa),
		.mstatus_mpie    (mstatus_mpie),
		.trap_ctrl       (trap_ctrl),
		.dtcm_en         (dtcm_en),
		.dtcm_start_addr (dtcm_start_addr),
		.trap            (trap),
		.read_data       (read_data)
	);

endmodule

// ==== bench/tb_clock_gen.sv ====
// testbench clock and reset generator
`timescale 1ns/1ns

module tb_clock_gen (
	output logic cpu_clk,
	output logic cpu_rstn
);

	initial
	begin
		cpu_clk = 1'b0;
		forever #20 cpu_clk = ~cpu_clk;    // 40 ns period
	end

	initial
	begin
		cpu_rstn = 1'b0;
		repeat (16) @(posedge cpu_clk);
		#2;
		cpu_rstn = 1'b1;
	end

endmodule

// ==== bench/mcsr_tb.sv ====
// directed testbench for the machine CSR block with check task and expected values
`timescale 1ns/1ns
`include "mcsr_config.svh"

module mcsr_tb;

	logic                        cpu_clk;
	logic                        cpu_rstn;
	mcsr_pkg::csr_req_t          req;
	mcsr_pkg::trap_info_t        trap;
	logic [`MCSR_DATA_WIDTH-1:0] read_data;
	logic                        mepc_sel;
	logic                        mcause_sel;
	logic                        mtval_sel;
	logic                        csr_illegal_access;
	logic [`MCSR_INSTR_WIDTH-1:0] illegal_instr;
	mcsr_pkg::trap_ctrl_t        trap_ctrl;
	logic                        dtcm_en;
	logic [`MCSR_ADDR_WIDTH-1:0] dtcm_start_addr;
	integer                      seed = 32'he4a3_c7a1;

	tb_clock_gen u_clk (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn)
	);

	mcsr_top UUT (
		.cpu_clk            (cpu_clk),
		.cpu_rstn           (cpu_rstn),
		.req                (req),
		.trap               (trap),
		.read_data          (read_data),
		.mepc_sel           (mepc_sel),
		.mcause_sel         (mcause_sel),
		.mtval_sel          (mtval_sel),
		.csr_illegal_access (csr_illegal_access),
		.illegal_instr      (illegal_instr),
		.trap_ctrl          (trap_ctrl),
		.dtcm_en            (dtcm_en),
		.dtcm_start_addr    (dtcm_start_addr)
	);

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Checks failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// expected register value after write, set or clear
	function automatic logic [31:0] expect_op(input mcsr_pkg::csr_op_e op,
		input logic [31:0] old, input logic [31:0] data);
		logic [31:0] result;
		result = old;
		if (op == mcsr_pkg::CSR_OP_WRITE)
			result = data;
		else if (op == mcsr_pkg::CSR_OP_SET)
			result = old | data;
		else if (op == mcsr_pkg::CSR_OP_CLEAR)
			result = old & ~data;
		return result;
	endfunction

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (cpu_rstn !== 1'b1)
		begin
			@(posedge cpu_clk);
			cycles++;
			if (cycles > 100)
			begin
				$display("reset was not released within 100 clock cycles");
				$display("Checks failed");
				$fatal(1, "reset timeout");
			end
		end
	endtask

	// one access, driven after the edge and sampled at the falling edge
	task automatic access(input logic [11:0] addr, input mcsr_pkg::csr_op_e op, input logic rd,
		input logic wr, input logic valid, input logic [31:0] wdata, input logic [31:0] instr);
		@(posedge cpu_clk);
		#2;
		req.addr     = addr;
		req.op       = op;
		req.rd       = rd;
		req.wr       = wr;
		req.valid_rd = rd & valid;
		req.valid_wr = wr & valid;
		req.wdata    = wdata;
		req.instr    = instr;
		@(negedge cpu_clk);
	endtask

	task automatic read_csr(input logic [11:0] addr, input logic [31:0] exp, input string name);
		access(addr, mcsr_pkg::CSR_OP_WRITE, 1'b1, 1'b0, 1'b1, 32'h0, 32'h0);
		check(name, read_data, exp);
	endtask

	task automatic write_csr(input logic [11:0] addr, input mcsr_pkg::csr_op_e op,
		input logic [31:0] data);
		access(addr, op, 1'b0, 1'b1, 1'b1, data, 32'h0);
	endtask

	task automatic pulse_trap(input logic irq, input logic ret);
		@(posedge cpu_clk);
		#2;
		req                  = '0;
		trap.valid_interrupt = irq;
		trap.mret            = ret;
		@(posedge cpu_clk);
		#2;
		trap.valid_interrupt = 1'b0;    // single-cycle pulse
		trap.mret            = 1'b0;
	endtask

	task automatic reset_values();
		read_csr(`MCSR_MISA_ADDR, 32'h4000_0100, "misa");
		read_csr(`MCSR_MIMPID_ADDR, 32'h1000_0000, "mimpid");
		read_csr(`MCSR_MSTATUS_ADDR, 32'h0, "mstatus");
		read_csr(`MCSR_MIE_ADDR, 32'h880, "mie");
		read_csr(`MCSR_MTVEC_ADDR, `MCSR_VECTOR_ENTRY, "mtvec");
		read_csr(`MCSR_TCM_CTRL_ADDR, 32'h1, "tcm_ctrl");
		read_csr(`MCSR_DTCM_START_ADDR_ADDR, `MCSR_DTCM_START_ADDR, "dtcm_start");
		check("trap_ctrl.meie", trap_ctrl.meie, 1);
		check("trap_ctrl.mtie", trap_ctrl.mtie, 1);
		check("trap_ctrl.mstatus_mie", trap_ctrl.mstatus_mie, 0);
		check("trap_ctrl.mtvec_mode", trap_ctrl.mtvec_mode, 0);
		check("trap_ctrl.mtvec_base", trap_ctrl.mtvec_base, `MCSR_VECTOR_ENTRY & 32'hFFFF_FFFC);
		check("dtcm_en", dtcm_en, 1);
		check("dtcm_start_addr", dtcm_start_addr, `MCSR_DTCM_START_ADDR);
	endtask

	task automatic write_set_clear();
		logic [31:0]       dtcm_model;
		logic [31:0]       mtvec_model;
		logic [25:0]       misa_model;
		logic [31:0]       data;
		logic [31:0]       tmp;
		mcsr_pkg::csr_op_e op;
		dtcm_model  = `MCSR_DTCM_START_ADDR;
		mtvec_model = `MCSR_VECTOR_ENTRY;
		misa_model  = `MCSR_MISA_RESET;
		for (int i = 0; i < 6; i++)
		begin
			op   = mcsr_pkg::csr_op_e'(i % 3);    // write, set, clear in turn
			data = $random(seed);
			write_csr(`MCSR_DTCM_START_ADDR_ADDR, op, data);
			dtcm_model = expect_op(op, dtcm_model, data);
			read_csr(`MCSR_DTCM_START_ADDR_ADDR, dtcm_model, "dtcm_start");
			check("dtcm_start_addr", dtcm_start_addr, dtcm_model);

			data = $random(seed);
			write_csr(`MCSR_MTVEC_ADDR, op, data);
			mtvec_model = expect_op(op, mtvec_model, data);
			read_csr(`MCSR_MTVEC_ADDR, mtvec_model, "mtvec");
			check("trap_ctrl.mtvec_mode", trap_ctrl.mtvec_mode, mtvec_model[1:0]);
			check("trap_ctrl.mtvec_base", trap_ctrl.mtvec_base, {mtvec_model[31:2], 2'b00});

			data = $random(seed);
			write_csr(`MCSR_MISA_ADDR, op, data);
			tmp        = expect_op(op, {6'h0, misa_model}, data);
			misa_model = tmp[25:0];    // only the extension field is stored
			read_csr(`MCSR_MISA_ADDR, {2'b01, 4'h0, misa_model}, "misa");
		end
	endtask

	task automatic illegal_accesses();
		logic [31:0] dtcm_before;
		logic [31:0] mtvec_before;
		dtcm_before  = dtcm_start_addr;
		mtvec_before = trap_ctrl.mtvec_base;
		access(`MCSR_MHARTID_ADDR, mcsr_pkg::CSR_OP_WRITE, 1'b0, 1'b1, 1'b1,
			32'hFFFF_FFFF, 32'hF140_1073);
		check("csr_illegal_access", csr_illegal_access, 1);
		check("illegal_instr", illegal_instr, 32'hF140_1073);
		read_csr(`MCSR_MHARTID_ADDR, 32'h0, "mhartid");
		check("csr_illegal_access", csr_illegal_access, 0);
		check("dtcm_start_addr", dtcm_start_addr, dtcm_before);
		check("trap_ctrl.mtvec_base", trap_ctrl.mtvec_base, mtvec_before);
		check("dtcm_en", dtcm_en, 1);

		// nothing lives at 0x7ff
		access(12'h7FF, mcsr_pkg::CSR_OP_WRITE, 1'b1, 1'b0, 1'b1, 32'h0, 32'h7FF0_2573);
		check("csr_illegal_access", csr_illegal_access, 1);
		check("illegal_instr", illegal_instr, 32'h7FF0_2573);

		// legal dummy read carries an instruction word too
		access(`MCSR_SATP_ADDR, mcsr_pkg::CSR_OP_WRITE, 1'b1, 1'b0, 1'b1,
			32'h0, 32'h1800_2573);
		check("satp", read_data, 32'h0);
		check("csr_illegal_access", csr_illegal_access, 0);
		check("illegal_instr", illegal_instr, 32'h0);
	endtask

	task automatic interrupt_entry_return();
		write_csr(`MCSR_MSTATUS_ADDR, mcsr_pkg::CSR_OP_SET, 32'h8);
		read_csr(`MCSR_MSTATUS_ADDR, 32'h8, "mstatus");
		check("trap_ctrl.mstatus_mie", trap_ctrl.mstatus_mie, 1);
		pulse_trap(1'b1, 1'b0);
		read_csr(`MCSR_MSTATUS_ADDR, 32'h80, "mstatus");    // MPIE set, MIE cleared
		check("trap_ctrl.mstatus_mie", trap_ctrl.mstatus_mie, 0);
		pulse_trap(1'b0, 1'b1);
		read_csr(`MCSR_MSTATUS_ADDR, 32'h88, "mstatus");
		// MIE off with MPIE on, so a wrongly taken mret would show
		write_csr(`MCSR_MSTATUS_ADDR, mcsr_pkg::CSR_OP_CLEAR, 32'h8);
		read_csr(`MCSR_MSTATUS_ADDR, 32'h80, "mstatus");
		pulse_trap(1'b0, 1'b1);    // no interrupt active now
		read_csr(`MCSR_MSTATUS_ADDR, 32'h80, "mstatus");
		check("trap_ctrl.mstatus_mie", trap_ctrl.mstatus_mie, 0);
	endtask

	task automatic pass_through_values();
		logic [31:0] epc;
		logic [31:0] cause;
		logic [31:0] tval;
		epc   = $random(seed);
		cause = $random(seed);
		tval  = $random(seed);
		@(posedge cpu_clk);
		#2;
		trap.meip = 1'b1;
		trap.mtip = 1'b0;
		read_csr(`MCSR_MIP_ADDR, 32'h800, "mip");
		@(posedge cpu_clk);
		#2;
		trap.meip   = 1'b0;
		trap.mtip   = 1'b1;
		trap.mepc   = epc;
		trap.mcause = cause;
		trap.mtval  = tval;
		read_csr(`MCSR_MIP_ADDR, 32'h80, "mip");
		read_csr(`MCSR_MEPC_ADDR, epc, "mepc");
		check("mepc_sel", mepc_sel, 1);
		check("mcause_sel", mcause_sel, 0);
		check("mtval_sel", mtval_sel, 0);
		read_csr(`MCSR_MCAUSE_ADDR, cause, "mcause");
		check("mcause_sel", mcause_sel, 1);
		read_csr(`MCSR_MTVAL_ADDR, tval, "mtval");
		check("mtval_sel", mtval_sel, 1);
		check("mepc_sel", mepc_sel, 0);
		// rd intent without the strobe
		access(`MCSR_MIMPID_ADDR, mcsr_pkg::CSR_OP_WRITE, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
		check("read_data", read_data, 32'h0);
	endtask

	initial
	begin
		req  = '0;
		trap = '0;
		wait_reset_release();
		reset_values();
		write_set_clear();
		illegal_accesses();
		interrupt_entry_return();
		pass_through_values();
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+src
src/mcsr_pkg.sv
src/csr_addr_decode.sv
src/csr_trap_regs.sv
src/csr_isa_tcm_regs.sv
src/csr_read_mux.sv
src/mcsr_top.sv
bench/tb_clock_gen.sv
bench/mcsr_tb.sv

// ==== Bender.yml ====
package:
  name: mcsr

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/mcsr_pkg.sv
      - src/csr_addr_decode.sv
      - src/csr_trap_regs.sv
      - src/csr_isa_tcm_regs.sv
      - src/csr_read_mux.sv
      - src/mcsr_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - bench/tb_clock_gen.sv
      - bench/mcsr_tb.sv
